// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } alu_op_e;

  // Any other primary opcode decodes as a no-op
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a
  } funct_e;

  typedef struct packed {
    alu_op_e   alu_op;
    data_t     operand_a;
    data_t     operand_b;
    logic [4:0] shamt;
    logic      mem_read;
    logic      mem_write;
    data_t     store_data;
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    addr_t     pc;
  } id_ex_t;

  typedef struct packed {
    data_t     result;
    logic      mem_read;
    logic      mem_write;
    data_t     store_data;
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    addr_t     pc;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    data_t     data;
    addr_t     pc;
  } wb_t;

  // is_load marks data that is not ready yet
  typedef struct packed {
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    data_t     data;
    logic      is_load;
  } fwd_t;

endpackage

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
  parameter core_pkg::addr_t RESET_PC = '0
) (
  input  wire              clk_i,
  input  wire              reset_i,
  input  wire              stall_i,
  input  wire              hold_i,
  input  wire              branch_taken_i,
  input  core_pkg::addr_t  branch_target_i,
  output logic             rom_en_o,
  output core_pkg::addr_t  rom_addr_o,
  input  core_pkg::inst_t  rom_data_i,
  output core_pkg::addr_t  if_pc_o,
  output core_pkg::inst_t  if_inst_o,
  output logic             if_valid_o
);

  import core_pkg::*;

  logic  fetch_en_q;
  addr_t pc_q;
  addr_t if_pc_q;
  inst_t if_inst_q;
  logic  if_valid_q;
  logic  advance;

  // Decode or the outside world may freeze the front end
  assign advance = fetch_en_q & ~stall_i & ~hold_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_en_q <= 1'b0;
      pc_q       <= RESET_PC;
    end else begin
      fetch_en_q <= 1'b1;
      if (advance) begin
        // The delay slot is already on the ROM when a branch resolves
        pc_q <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      if_valid_q <= 1'b0;
    end else if (!stall_i && !hold_i) begin
      if_valid_q <= fetch_en_q;
      if_pc_q    <= pc_q;
      if_inst_q  <= rom_data_i;
    end
  end

  assign rom_en_o   = fetch_en_q;
  assign rom_addr_o = pc_q;
  assign if_pc_o    = if_pc_q;
  assign if_inst_o  = if_inst_q;
  assign if_valid_o = if_valid_q;

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  wire                  clk_i,
  input  wire                  reset_i,
  input  wire                  stall_i,
  input  core_pkg::addr_t      if_pc_i,
  input  core_pkg::inst_t      if_inst_i,
  input  wire                  if_valid_i,
  output core_pkg::reg_addr_t  rs_addr_o,
  output core_pkg::reg_addr_t  rt_addr_o,
  input  core_pkg::data_t      rs_data_i,
  input  core_pkg::data_t      rt_data_i,
  input  wire                  load_hazard_i,
  output logic                 hold_o,
  output logic                 branch_taken_o,
  output core_pkg::addr_t      branch_target_o,
  output core_pkg::id_ex_t     id_ex_o
);

  import core_pkg::*;

  opcode_e   opcode;
  funct_e    funct;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  logic [4:0] shamt;
  data_t     imm_sext;
  data_t     imm_zext;
  logic      uses_rt;
  logic      operands_equal;
  logic      branch_cond;
  id_ex_t    id_ex_d;
  id_ex_t    id_ex_q;

  assign opcode   = opcode_e'(if_inst_i[31:26]);
  assign funct    = funct_e'(if_inst_i[5:0]);
  assign rs       = if_inst_i[25:21];
  assign rt       = if_inst_i[20:16];
  assign rd       = if_inst_i[15:11];
  assign shamt    = if_inst_i[10:6];
  assign imm_sext = {{16{if_inst_i[15]}}, if_inst_i[15:0]};
  assign imm_zext = {16'h0000, if_inst_i[15:0]};

  // rt is only a source for R-type, stores and branches
  assign uses_rt = (opcode == OP_SPECIAL) || (opcode == OP_SW) ||
                   (opcode == OP_BEQ) || (opcode == OP_BNE);

  assign rs_addr_o = rs;
  assign rt_addr_o = uses_rt ? rt : '0;

  assign hold_o = if_valid_i & load_hazard_i;

  // Branches compare forwarded operands
  assign operands_equal  = (rs_data_i == rt_data_i);
  assign branch_cond     = ((opcode == OP_BEQ) && operands_equal) ||
                           ((opcode == OP_BNE) && !operands_equal);
  assign branch_taken_o  = if_valid_i & branch_cond & ~load_hazard_i;
  assign branch_target_o = if_pc_i + 32'd4 + {imm_sext[29:0], 2'b00};

  always_comb begin
    id_ex_d            = '0;
    id_ex_d.pc         = if_pc_i;
    id_ex_d.operand_a  = rs_data_i;
    id_ex_d.operand_b  = rt_data_i;
    id_ex_d.shamt      = shamt;
    id_ex_d.store_data = rt_data_i;
    case (opcode)
      OP_SPECIAL: begin
        id_ex_d.reg_write_en   = 1'b1;
        id_ex_d.reg_write_addr = rd;
        case (funct)
          FN_ADDU: id_ex_d.alu_op = ALU_ADD;
          FN_SUBU: id_ex_d.alu_op = ALU_SUB;
          FN_AND:  id_ex_d.alu_op = ALU_AND;
          FN_OR:   id_ex_d.alu_op = ALU_OR;
          FN_XOR:  id_ex_d.alu_op = ALU_XOR;
          FN_SLT:  id_ex_d.alu_op = ALU_SLT;
          FN_SLL:  id_ex_d.alu_op = ALU_SLL;
          FN_SRL:  id_ex_d.alu_op = ALU_SRL;
          default: id_ex_d.reg_write_en = 1'b0;
        endcase
      end
      OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW: begin
        id_ex_d.reg_write_en   = 1'b1;
        id_ex_d.reg_write_addr = rt;
        id_ex_d.operand_b      = imm_sext;
        id_ex_d.mem_read       = (opcode == OP_LW);
        if (opcode == OP_ANDI) begin
          id_ex_d.alu_op    = ALU_AND;
          id_ex_d.operand_b = imm_zext;
        end else if (opcode == OP_ORI) begin
          id_ex_d.alu_op    = ALU_OR;
          id_ex_d.operand_b = imm_zext;
        end else if (opcode == OP_LUI) begin
          id_ex_d.alu_op    = ALU_LUI;
          id_ex_d.operand_b = imm_zext;
        end
      end
      OP_SW: begin
        id_ex_d.operand_b = imm_sext;
        id_ex_d.mem_write = 1'b1;
      end
      default: ;
    endcase
    // $zero is never written
    if (id_ex_d.reg_write_addr == '0) begin
      id_ex_d.reg_write_en = 1'b0;
    end
    // Empty slot or load-use bubble
    if (!if_valid_i || hold_o) begin
      id_ex_d.reg_write_en = 1'b0;
      id_ex_d.mem_read     = 1'b0;
      id_ex_d.mem_write    = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_ex_q.reg_write_en <= 1'b0;
      id_ex_q.mem_read     <= 1'b0;
      id_ex_q.mem_write    <= 1'b0;
    end else if (!stall_i) begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

  // A branch waiting on a load must not redirect fetch until its operands arrive
  a_no_branch_on_hold: assert property (
    @(posedge clk_i) disable iff (reset_i) hold_o |-> !branch_taken_o
  );

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  wire                  clk_i,
  input  wire                  reset_i,
  input  core_pkg::reg_addr_t  rs_addr_i,
  input  core_pkg::reg_addr_t  rt_addr_i,
  input  core_pkg::fwd_t       ex_fwd_i,
  input  core_pkg::fwd_t       mem_fwd_i,
  input  core_pkg::wb_t        wb_i,
  output core_pkg::data_t      rs_data_o,
  output core_pkg::data_t      rt_data_o,
  output logic                 load_hazard_o
);

  import core_pkg::*;

  data_t regs [0:31];

  // Youngest producer wins
  function automatic data_t read_port(input reg_addr_t addr, input data_t stored,
                                      input fwd_t ex_src, input fwd_t mem_src,
                                      input wb_t wb_src);
    data_t value;
    if (addr == '0) begin
      value = '0;
    end else if (ex_src.reg_write_en && ex_src.reg_write_addr == addr) begin
      value = ex_src.data;
    end else if (mem_src.reg_write_en && mem_src.reg_write_addr == addr) begin
      value = mem_src.data;
    end else if (wb_src.reg_write_en && wb_src.reg_write_addr == addr) begin
      value = wb_src.data;
    end else begin
      value = stored;
    end
    return value;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!reset_i && wb_i.reg_write_en) begin
      regs[wb_i.reg_write_addr] <= wb_i.data;
    end
  end

  assign rs_data_o = read_port(rs_addr_i, regs[rs_addr_i], ex_fwd_i, mem_fwd_i, wb_i);
  assign rt_data_o = read_port(rt_addr_i, regs[rt_addr_i], ex_fwd_i, mem_fwd_i, wb_i);

  // Load data only exists one stage later
  assign load_hazard_o = ex_fwd_i.is_load && ex_fwd_i.reg_write_en &&
                         (((rs_addr_i != '0) && (rs_addr_i == ex_fwd_i.reg_write_addr)) ||
                          ((rt_addr_i != '0) && (rt_addr_i == ex_fwd_i.reg_write_addr)));

  // Decode drops writes to $zero before they reach writeback
  a_no_zero_write: assert property (
    @(posedge clk_i) disable iff (reset_i) wb_i.reg_write_en |-> wb_i.reg_write_addr != '0
  );

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input  wire                clk_i,
  input  wire                reset_i,
  input  wire                stall_i,
  input  core_pkg::id_ex_t   id_ex_i,
  output core_pkg::fwd_t     ex_fwd_o,
  output core_pkg::ex_mem_t  ex_mem_o
);

  import core_pkg::*;

  data_t   alu_result;
  ex_mem_t ex_mem_q;

  // Shifts and lui work on operand_b
  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD: alu_result = id_ex_i.operand_a + id_ex_i.operand_b;
      ALU_SUB: alu_result = id_ex_i.operand_a - id_ex_i.operand_b;
      ALU_AND: alu_result = id_ex_i.operand_a & id_ex_i.operand_b;
      ALU_OR:  alu_result = id_ex_i.operand_a | id_ex_i.operand_b;
      ALU_XOR: alu_result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      ALU_SLT: begin
        alu_result = {31'b0, $signed(id_ex_i.operand_a) < $signed(id_ex_i.operand_b)};
      end
      ALU_SLL: alu_result = id_ex_i.operand_b << id_ex_i.shamt;
      ALU_SRL: alu_result = id_ex_i.operand_b >> id_ex_i.shamt;
      ALU_LUI: alu_result = {id_ex_i.operand_b[15:0], 16'h0000};
      default: alu_result = '0;
    endcase
  end

  // For a load the result is only the address
  assign ex_fwd_o.reg_write_en   = id_ex_i.reg_write_en;
  assign ex_fwd_o.reg_write_addr = id_ex_i.reg_write_addr;
  assign ex_fwd_o.data           = alu_result;
  assign ex_fwd_o.is_load        = id_ex_i.mem_read;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_mem_q.reg_write_en <= 1'b0;
      ex_mem_q.mem_read     <= 1'b0;
      ex_mem_q.mem_write    <= 1'b0;
    end else if (!stall_i) begin
      ex_mem_q.result         <= alu_result;
      ex_mem_q.mem_read       <= id_ex_i.mem_read;
      ex_mem_q.mem_write      <= id_ex_i.mem_write;
      ex_mem_q.store_data     <= id_ex_i.store_data;
      ex_mem_q.reg_write_en   <= id_ex_i.reg_write_en;
      ex_mem_q.reg_write_addr <= id_ex_i.reg_write_addr;
      ex_mem_q.pc             <= id_ex_i.pc;
    end
  end

  assign ex_mem_o = ex_mem_q;

  a_one_mem_op: assert property (
    @(posedge clk_i) disable iff (reset_i) !(id_ex_i.mem_read && id_ex_i.mem_write)
  );

endmodule

`default_nettype wire

// File: src/memory_stage.sv
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
  input  wire                clk_i,
  input  wire                reset_i,
  input  wire                stall_i,
  input  core_pkg::ex_mem_t  ex_mem_i,
  output logic               ram_en_o,
  output logic               ram_we_o,
  output core_pkg::addr_t    ram_addr_o,
  output core_pkg::data_t    ram_wdata_o,
  input  core_pkg::data_t    ram_rdata_i,
  output core_pkg::fwd_t     mem_fwd_o,
  output core_pkg::wb_t      wb_o
);

  import core_pkg::*;

  data_t stage_data;
  wb_t   wb_q;

  // Word access only
  assign ram_en_o    = ex_mem_i.mem_read | ex_mem_i.mem_write;
  assign ram_we_o    = ex_mem_i.mem_write & ~stall_i;
  assign ram_addr_o  = ex_mem_i.result;
  assign ram_wdata_o = ex_mem_i.store_data;

  assign stage_data = ex_mem_i.mem_read ? ram_rdata_i : ex_mem_i.result;

  assign mem_fwd_o.reg_write_en   = ex_mem_i.reg_write_en;
  assign mem_fwd_o.reg_write_addr = ex_mem_i.reg_write_addr;
  assign mem_fwd_o.data           = stage_data;
  assign mem_fwd_o.is_load        = 1'b0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_q.reg_write_en <= 1'b0;
    end else if (!stall_i) begin
      wb_q.reg_write_en   <= ex_mem_i.reg_write_en;
      wb_q.reg_write_addr <= ex_mem_i.reg_write_addr;
      wb_q.data           <= stage_data;
      wb_q.pc             <= ex_mem_i.pc;
    end
  end

  // A held MEM/WB entry retires once, after the stall ends
  assign wb_o.reg_write_en   = wb_q.reg_write_en & ~stall_i;
  assign wb_o.reg_write_addr = wb_q.reg_write_addr;
  assign wb_o.data           = wb_q.data;
  assign wb_o.pc             = wb_q.pc;

  // A store held across a stall commits exactly once
  a_no_write_in_stall: assert property (
    @(posedge clk_i) disable iff (reset_i) stall_i |-> !ram_we_o
  );

endmodule

`default_nettype wire

// File: src/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top #(
  parameter core_pkg::addr_t RESET_PC = '0
) (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire                        stall_i,
  // ROM port
  output logic                       rom_en_o,
  output core_pkg::addr_t            rom_addr_o,
  input  core_pkg::inst_t            rom_data_i,
  // RAM port
  output logic                       ram_en_o,
  output logic                       ram_we_o,
  output core_pkg::addr_t            ram_addr_o,
  output core_pkg::data_t            ram_wdata_o,
  input  core_pkg::data_t            ram_rdata_i,
  // Debug writeback
  output logic                       debug_wb_en_o,
  output core_pkg::reg_addr_t        debug_wb_addr_o,
  output core_pkg::data_t            debug_wb_data_o,
  output core_pkg::addr_t            debug_pc_o
);

  import core_pkg::*;

  addr_t     if_pc;
  inst_t     if_inst;
  logic      if_valid;
  logic      hold;
  logic      branch_taken;
  addr_t     branch_target;
  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  data_t     rs_data;
  data_t     rt_data;
  logic      load_hazard;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  fwd_t      ex_fwd;
  fwd_t      mem_fwd;
  wb_t       wb;

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .stall_i         (stall_i),
    .hold_i          (hold),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .rom_en_o        (rom_en_o),
    .rom_addr_o      (rom_addr_o),
    .rom_data_i      (rom_data_i),
    .if_pc_o         (if_pc),
    .if_inst_o       (if_inst),
    .if_valid_o      (if_valid)
  );

  decode_stage u_decode (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .stall_i         (stall_i),
    .if_pc_i         (if_pc),
    .if_inst_i       (if_inst),
    .if_valid_i      (if_valid),
    .rs_addr_o       (rs_addr),
    .rt_addr_o       (rt_addr),
    .rs_data_i       (rs_data),
    .rt_data_i       (rt_data),
    .load_hazard_i   (load_hazard),
    .hold_o          (hold),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .id_ex_o         (id_ex)
  );

  reg_file u_reg_file (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .rs_addr_i     (rs_addr),
    .rt_addr_i     (rt_addr),
    .ex_fwd_i      (ex_fwd),
    .mem_fwd_i     (mem_fwd),
    .wb_i          (wb),
    .rs_data_o     (rs_data),
    .rt_data_o     (rt_data),
    .load_hazard_o (load_hazard)
  );

  execute_stage u_execute (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .stall_i  (stall_i),
    .id_ex_i  (id_ex),
    .ex_fwd_o (ex_fwd),
    .ex_mem_o (ex_mem)
  );

  memory_stage u_memory (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .stall_i     (stall_i),
    .ex_mem_i    (ex_mem),
    .ram_en_o    (ram_en_o),
    .ram_we_o    (ram_we_o),
    .ram_addr_o  (ram_addr_o),
    .ram_wdata_o (ram_wdata_o),
    .ram_rdata_i (ram_rdata_i),
    .mem_fwd_o   (mem_fwd),
    .wb_o        (wb)
  );

  assign debug_wb_en_o   = wb.reg_write_en;
  assign debug_wb_addr_o = wb.reg_write_addr;
  assign debug_wb_data_o = wb.data;
  assign debug_pc_o      = wb.pc;

endmodule

`default_nettype wire

// File: tb/core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module core_tb;

  localparam int CLK_HALF     = 5;
  localparam int CLK_PERIOD   = 2 * CLK_HALF;
  localparam int RESET_CYCLES = 2;
  localparam int RUN_LIMIT    = 200;
  localparam int DRAIN_CYCLES = 4;
  localparam int NUM_RUNS     = 5;
  localparam int WATCHDOG_NS  =
    NUM_RUNS * (RESET_CYCLES + RUN_LIMIT + DRAIN_CYCLES + 2) * CLK_PERIOD;
  localparam logic [31:0] RESET_PC = 32'h0000_0000;
  localparam logic [31:0] SEED     = 32'h5aa0_f8fc;

  // MIPS32 opcodes and function codes
  localparam int OP_BEQ   = 'h04;
  localparam int OP_BNE   = 'h05;
  localparam int OP_ADDIU = 'h09;
  localparam int OP_ANDI  = 'h0c;
  localparam int OP_ORI   = 'h0d;
  localparam int OP_LUI   = 'h0f;
  localparam int OP_LW    = 'h23;
  localparam int OP_SW    = 'h2b;
  localparam int FN_SLL   = 'h00;
  localparam int FN_SRL   = 'h02;
  localparam int FN_ADDU  = 'h21;
  localparam int FN_SUBU  = 'h23;
  localparam int FN_AND   = 'h24;
  localparam int FN_OR    = 'h25;
  localparam int FN_XOR   = 'h26;
  localparam int FN_SLT   = 'h2a;

  typedef struct packed {
    logic [4:0]  addr;
    logic [31:0] data;
    logic [31:0] pc;
  } wb_rec_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } ram_rec_t;

  logic        clk_i;
  logic        reset_i;
  logic        stall_i;
  logic        rom_en_o;
  logic [31:0] rom_addr_o;
  logic [31:0] rom_data_i;
  logic        ram_en_o;
  logic        ram_we_o;
  logic [31:0] ram_addr_o;
  logic [31:0] ram_wdata_o;
  logic [31:0] ram_rdata_i;
  logic        debug_wb_en_o;
  logic [4:0]  debug_wb_addr_o;
  logic [31:0] debug_wb_data_o;
  logic [31:0] debug_pc_o;

  logic [31:0] rom [0:255];
  logic [31:0] ram [0:255];
  wb_rec_t     wb_seen[$];
  wb_rec_t     wb_exp[$];
  ram_rec_t    ram_seen[$];
  ram_rec_t    ram_exp[$];
  int          errors;
  int          monitor_errors;
  int          prog_len;
  logic [31:0] lfsr;

  core_top u_dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .stall_i         (stall_i),
    .rom_en_o        (rom_en_o),
    .rom_addr_o      (rom_addr_o),
    .rom_data_i      (rom_data_i),
    .ram_en_o        (ram_en_o),
    .ram_we_o        (ram_we_o),
    .ram_addr_o      (ram_addr_o),
    .ram_wdata_o     (ram_wdata_o),
    .ram_rdata_i     (ram_rdata_i),
    .debug_wb_en_o   (debug_wb_en_o),
    .debug_wb_addr_o (debug_wb_addr_o),
    .debug_wb_data_o (debug_wb_data_o),
    .debug_pc_o      (debug_pc_o)
  );

  always #CLK_HALF clk_i = ~clk_i;

  // Both memories answer in the same cycle
  assign rom_data_i  = rom[rom_addr_o[9:2]];
  assign ram_rdata_i = ram[ram_addr_o[9:2]];

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0] ^ 16'h3c3c, addr[15:0]};
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  function automatic logic [31:0] i_inst(input int op, input int rt, input int rs,
                                         input int imm);
    return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] r_inst(input int fn, input int rd, input int rs,
                                         input int rt, input int sh);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn[5:0]};
  endfunction

  // RAM refill on reset and logging of writes and writebacks
  always @(posedge clk_i) begin
    wb_rec_t  wb_rec;
    ram_rec_t ram_rec;
    if (reset_i) begin
      wb_seen.delete();
      ram_seen.delete();
      for (int i = 0; i < 256; i++) begin
        ram[i] <= fill_word(i * 4);
      end
    end else begin
      if (stall_i && (debug_wb_en_o || ram_we_o)) begin
        $display("Writeback or RAM write during a stalled cycle, pc %h", debug_pc_o);
        monitor_errors++;
      end
      if (debug_wb_en_o) begin
        wb_rec.addr = debug_wb_addr_o;
        wb_rec.data = debug_wb_data_o;
        wb_rec.pc   = debug_pc_o;
        wb_seen.push_back(wb_rec);
      end
      if (ram_we_o) begin
        ram[ram_addr_o[9:2]] <= ram_wdata_o;
        ram_rec.addr = ram_addr_o;
        ram_rec.data = ram_wdata_o;
        ram_seen.push_back(ram_rec);
      end
    end
  end

  // Unused words decode as no-ops with rs and rt at zero
  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      rom[i] = {6'h3f, 10'h000, i[15:0]};
    end
    prog_len = 0;
    wb_exp.delete();
    ram_exp.delete();
  endtask

  task automatic put_inst(input logic [31:0] word);
    rom[prog_len] = word;
    prog_len++;
  endtask

  task automatic expect_wb(input int rd, input int data, input int pc);
    wb_rec_t rec;
    rec.addr = rd[4:0];
    rec.data = data;
    rec.pc   = pc;
    wb_exp.push_back(rec);
  endtask

  task automatic expect_ram(input int addr, input int data);
    ram_rec_t rec;
    rec.addr = addr;
    rec.data = data;
    ram_exp.push_back(rec);
  endtask

  task automatic check_reset_outputs(input string name);
    if (rom_en_o !== 1'b0 || ram_en_o !== 1'b0 || ram_we_o !== 1'b0 ||
        debug_wb_en_o !== 1'b0) begin
      $display("CHECK FAILED %s: controls in reset expected 0000 actual %b%b%b%b", name,
               rom_en_o, ram_en_o, ram_we_o, debug_wb_en_o);
      errors++;
    end
  endtask

  task automatic compare_results(input string name);
    if (wb_seen.size() != wb_exp.size()) begin
      $display("CHECK FAILED %s: writeback count expected %0d actual %0d", name,
               wb_exp.size(), wb_seen.size());
      errors++;
    end
    if (ram_seen.size() != ram_exp.size()) begin
      $display("CHECK FAILED %s: RAM write count expected %0d actual %0d", name,
               ram_exp.size(), ram_seen.size());
      errors++;
    end
    for (int i = 0; i < wb_exp.size() && i < wb_seen.size(); i++) begin
      if (wb_seen[i] !== wb_exp[i]) begin
        $display("CHECK FAILED %s: writeback %0d expected r%0d=%h pc %h actual r%0d=%h pc %h",
                 name, i, wb_exp[i].addr, wb_exp[i].data, wb_exp[i].pc,
                 wb_seen[i].addr, wb_seen[i].data, wb_seen[i].pc);
        errors++;
      end
    end
    for (int i = 0; i < ram_exp.size() && i < ram_seen.size(); i++) begin
      if (ram_seen[i] !== ram_exp[i]) begin
        $display("CHECK FAILED %s: RAM write %0d expected [%h]=%h actual [%h]=%h", name, i,
                 ram_exp[i].addr, ram_exp[i].data, ram_seen[i].addr, ram_seen[i].data);
        errors++;
      end
    end
  endtask

  task automatic run_program(input string name, input bit use_stall);
    int cycles;
    bit fetch_seen;
    cycles     = 0;
    fetch_seen = 1'b0;
    @(negedge clk_i);
    reset_i = 1'b1;
    stall_i = 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge clk_i);
      check_reset_outputs(name);
    end
    reset_i = 1'b0;
    while ((wb_seen.size() < wb_exp.size() || ram_seen.size() < ram_exp.size()) &&
           cycles < RUN_LIMIT) begin
      @(negedge clk_i);
      if (rom_en_o && !fetch_seen) begin
        fetch_seen = 1'b1;
        if (rom_addr_o !== RESET_PC) begin
          $display("CHECK FAILED %s: first fetch expected %h actual %h", name,
                   RESET_PC, rom_addr_o);
          errors++;
        end
      end
      if (use_stall) begin
        lfsr    = lfsr_step(lfsr);
        stall_i = lfsr[0];
      end
      cycles++;
    end
    if (cycles >= RUN_LIMIT) begin
      $display("%s: program did not finish within %0d cycles", name, RUN_LIMIT);
      errors++;
    end
    // Catch late or repeated writes
    stall_i = 1'b0;
    repeat (DRAIN_CYCLES) @(negedge clk_i);
    compare_results(name);
  endtask

  task automatic test_alu_chain();
    clear_program();
    put_inst(i_inst(OP_ADDIU, 1, 0, 'h1234));
    put_inst(i_inst(OP_ADDIU, 2, 1, -4));
    put_inst(r_inst(FN_ADDU, 3, 1, 2, 0));
    put_inst(r_inst(FN_SUBU, 4, 1, 3, 0));
    put_inst(r_inst(FN_AND, 5, 4, 3, 0));
    put_inst(r_inst(FN_OR, 6, 5, 1, 0));
    put_inst(r_inst(FN_XOR, 7, 6, 4, 0));
    put_inst(r_inst(FN_SLT, 8, 7, 6, 0));
    put_inst(r_inst(FN_SLT, 9, 6, 7, 0));
    put_inst(r_inst(FN_SLL, 10, 0, 6, 4));
    put_inst(r_inst(FN_SRL, 11, 0, 7, 8));
    put_inst(i_inst(OP_LUI, 12, 0, 'hbeef));
    put_inst(i_inst(OP_ORI, 13, 12, 'h00f0));
    put_inst(i_inst(OP_ANDI, 14, 13, 'h80ff));
    put_inst(i_inst(OP_ADDIU, 15, 14, -32768));
    expect_wb(1, 32'h0000_1234, 'h00);
    expect_wb(2, 32'h0000_1230, 'h04);
    expect_wb(3, 32'h0000_2464, 'h08);
    expect_wb(4, 32'hffff_edd0, 'h0c);
    expect_wb(5, 32'h0000_2440, 'h10);
    expect_wb(6, 32'h0000_3674, 'h14);
    expect_wb(7, 32'hffff_dba4, 'h18);
    expect_wb(8, 32'h0000_0001, 'h1c);
    expect_wb(9, 32'h0000_0000, 'h20);
    expect_wb(10, 32'h0003_6740, 'h24);
    expect_wb(11, 32'h00ff_ffdb, 'h28);
    expect_wb(12, 32'hbeef_0000, 'h2c);
    expect_wb(13, 32'hbeef_00f0, 'h30);
    expect_wb(14, 32'h0000_00f0, 'h34);
    expect_wb(15, 32'hffff_80f0, 'h38);
    run_program("alu_chain", 1'b0);
  endtask

  // Stores, loads and load-use cases shared by the stall rerun
  task automatic build_load_store();
    clear_program();
    put_inst(i_inst(OP_ADDIU, 1, 0, 'h0100));
    put_inst(i_inst(OP_LUI, 2, 0, 'h1357));
    put_inst(i_inst(OP_ORI, 2, 2, 'h9bdf));
    put_inst(i_inst(OP_SW, 2, 1, 0));
    put_inst(i_inst(OP_SW, 1, 1, 8));
    put_inst(i_inst(OP_ADDIU, 3, 2, 1));
    put_inst(i_inst(OP_SW, 3, 1, -4));
    put_inst(i_inst(OP_LW, 4, 1, 0));
    put_inst(r_inst(FN_ADDU, 5, 4, 4, 0));
    put_inst(i_inst(OP_LW, 6, 1, 8));
    put_inst(i_inst(OP_LW, 7, 6, 0));
    put_inst(i_inst(OP_SW, 7, 6, 4));
    put_inst(i_inst(OP_LW, 8, 1, -4));
    put_inst(i_inst(OP_LW, 9, 0, 'h20));
    put_inst(r_inst(FN_SUBU, 10, 9, 8, 0));
    expect_wb(1, 32'h0000_0100, 'h00);
    expect_wb(2, 32'h1357_0000, 'h04);
    expect_wb(2, 32'h1357_9bdf, 'h08);
    expect_wb(3, 32'h1357_9be0, 'h14);
    expect_wb(4, 32'h1357_9bdf, 'h1c);
    expect_wb(5, 32'h26af_37be, 'h20);
    expect_wb(6, 32'h0000_0100, 'h24);
    expect_wb(7, 32'h1357_9bdf, 'h28);
    expect_wb(8, 32'h1357_9be0, 'h30);
    expect_wb(9, fill_word(32'h20), 'h34);
    expect_wb(10, fill_word(32'h20) - 32'h1357_9be0, 'h38);
    expect_ram('h100, 32'h1357_9bdf);
    expect_ram('h108, 32'h0000_0100);
    expect_ram('h0fc, 32'h1357_9be0);
    expect_ram('h104, 32'h1357_9bdf);
  endtask

  task automatic test_load_store();
    build_load_store();
    run_program("load_store", 1'b0);
  endtask

  task automatic test_stall();
    build_load_store();
    run_program("stall", 1'b1);
  endtask

  // Skipped words write r4, r8, r11 and r15 and must never retire
  task automatic test_branches();
    clear_program();
    put_inst(i_inst(OP_ADDIU, 1, 0, 5));
    put_inst(i_inst(OP_ADDIU, 2, 0, 5));
    put_inst(i_inst(OP_BEQ, 2, 1, 3));
    put_inst(i_inst(OP_ADDIU, 3, 0, 'h11));
    put_inst(i_inst(OP_ADDIU, 4, 0, 'h22));
    put_inst(i_inst(OP_ADDIU, 4, 0, 'h33));
    put_inst(i_inst(OP_BNE, 2, 1, 4));
    put_inst(i_inst(OP_ADDIU, 5, 0, 'h44));
    put_inst(i_inst(OP_ADDIU, 6, 0, 'h55));
    put_inst(i_inst(OP_BNE, 6, 5, 2));
    put_inst(i_inst(OP_ADDIU, 7, 0, 'h66));
    put_inst(i_inst(OP_ADDIU, 8, 0, 'h77));
    put_inst(i_inst(OP_BEQ, 6, 1, 5));
    put_inst(i_inst(OP_ADDIU, 9, 0, 'h88));
    put_inst(i_inst(OP_BEQ, 0, 0, 2));
    put_inst(i_inst(OP_ADDIU, 10, 0, 'h99));
    put_inst(i_inst(OP_ADDIU, 11, 0, 'haa));
    put_inst(i_inst(OP_ADDIU, 12, 0, 'hbb));
    put_inst(i_inst(OP_LW, 13, 0, 'h40));
    put_inst(i_inst(OP_BNE, 0, 13, 2));
    put_inst(i_inst(OP_ADDIU, 14, 0, 1));
    put_inst(i_inst(OP_ADDIU, 15, 0, 2));
    put_inst(i_inst(OP_ADDIU, 16, 0, 3));
    expect_wb(1, 5, 'h00);
    expect_wb(2, 5, 'h04);
    expect_wb(3, 'h11, 'h0c);
    expect_wb(5, 'h44, 'h1c);
    expect_wb(6, 'h55, 'h20);
    expect_wb(7, 'h66, 'h28);
    expect_wb(9, 'h88, 'h34);
    expect_wb(10, 'h99, 'h3c);
    expect_wb(12, 'hbb, 'h44);
    expect_wb(13, fill_word(32'h40), 'h48);
    expect_wb(14, 1, 'h50);
    expect_wb(16, 3, 'h58);
    run_program("branches", 1'b0);
  endtask

  task automatic test_reset_and_zero();
    clear_program();
    put_inst(i_inst(OP_ADDIU, 0, 0, 'h5a));
    put_inst(i_inst(OP_ADDIU, 1, 0, 7));
    put_inst(r_inst(FN_ADDU, 2, 0, 1, 0));
    put_inst(r_inst(FN_OR, 3, 0, 0, 0));
    put_inst(r_inst(FN_SLL, 0, 0, 1, 2));
    put_inst(r_inst(FN_ADDU, 4, 0, 0, 0));
    expect_wb(1, 7, 'h04);
    expect_wb(2, 7, 'h08);
    expect_wb(3, 0, 'h0c);
    expect_wb(4, 0, 'h14);
    run_program("reset_and_zero", 1'b0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("tests failed");
    $finish;
  end

  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    stall_i        = 1'b0;
    errors         = 0;
    monitor_errors = 0;
    lfsr           = SEED;
    test_alu_chain();
    test_load_store();
    test_branches();
    test_stall();
    test_reset_and_zero();
    $display("Errors: %0d in checks, %0d in the monitor", errors, monitor_errors);
    if (errors + monitor_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
src/core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/memory_stage.sv
src/core_top.sv
tb/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
OBJ_DIR   ?= obj_dir
FILE_LIST ?= compile.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILE_LIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf $(OBJ_DIR)
